//--- common/fetch_defs.svh
// Address width, word width, fetch depth and counter width defines
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Byte address width of the instruction bus
`define FETCH_AW 32

// Width of one instruction word
`define FETCH_DW 32

// Outstanding plus queued transactions allowed at once
// Response FIFO is sized to this value
`define FETCH_DEPTH 4

// Counter width covering 0 through FETCH_DEPTH
`define FETCH_CNT_W 3

`endif

//--- common/fetch_pkg.sv
// Privilege level enum and prefetcher state enum
package fetch_pkg;

  ////////////////////////////////////////
  // Privilege levels
  ////////////////////////////////////////

  // Two-bit encoding follows the usual RISC-V privilege numbering
  // Only user and machine mode exist in this core
  typedef enum logic [1:0]
  {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_t;

  ////////////////////////////////////////
  // Prefetcher FSM
  ////////////////////////////////////////

  // IDLE
  //   Branch target or incremented address goes out directly
  // BRANCH_WAIT
  //   Branch target was not granted in its own cycle
  //   Target is replayed until the bus takes it
  typedef enum logic
  {
    IDLE,
    BRANCH_WAIT
  } prefetch_state_e;

endpackage

//--- common/fetch_ctrl_if.sv
// Issue controller to prefetcher interface with ctrl and pf modports
`include "fetch_defs.svh"

interface fetch_ctrl_if import fetch_pkg::*; ();

  // Taken branch strobe and its target
  logic                branch;
  logic [`FETCH_AW-1:0] branch_addr;

  // A transaction is wanted
  logic                valid;

  // Bus accepted the transaction this cycle
  logic                ready;

  // Pointer access flag of the branch target fetch
  logic                ptr;

  // Privilege level for the fetch
  privlvl_t            priv;

  // Issue controller side
  modport ctrl (
    output branch,
    output branch_addr,
    output valid,
    output ptr,
    output priv,
    input  ready
  );

  // Prefetcher side
  modport pf (
    input  branch,
    input  branch_addr,
    input  valid,
    input  ptr,
    input  priv,
    output ready
  );

endinterface

//--- common/fetch_resp_if.sv
// Response FIFO to issue controller interface with fifo and ctrl modports
`include "fetch_defs.svh"

interface fetch_resp_if ();

  // FIFO holds at least one word
  logic                 not_empty;

  // Oldest queued word
  logic [`FETCH_DW-1:0] head;

  // Remove the head word on the next edge
  logic                 pop;

  // Drop all queued words on the next edge
  logic                 flush;

  // Current response belongs to the live stream
  logic                 keep;

  // FIFO side
  modport fifo (
    output not_empty,
    output head,
    input  pop,
    input  flush,
    input  keep
  );

  // Issue controller side
  modport ctrl (
    input  not_empty,
    input  head,
    output pop,
    output flush,
    output keep
  );

endinterface

//--- prefetch/fetch_prefetcher.sv
// Transaction address generator with branch target replay FSM
`include "fetch_defs.svh"

module fetch_prefetcher import fetch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Control from the issue controller
  fetch_ctrl_if.pf             fc_if,

  // Transaction request toward the bus
  output logic                 trans_valid_o,
  input  logic                 trans_ready_i,
  output logic [`FETCH_AW-1:0] trans_addr_o,
  output logic                 trans_ptr_o,
  output privlvl_t             trans_priv_o
);

  prefetch_state_e      state_q;
  prefetch_state_e      state_d;

  // Last address, pointer flag and privilege sent or pending
  logic [`FETCH_AW-1:0] addr_q;
  logic                 ptr_q;
  privlvl_t             priv_q;

  // Next sequential word address
  logic [`FETCH_AW-1:0] addr_incr;

  // Bus took the transaction this cycle
  logic                 accepted;

  ////////////////////////////////////////
  // Request handshake
  ////////////////////////////////////////

  // Controller decides when a fetch is allowed
  assign trans_valid_o = fc_if.valid;
  assign accepted      = trans_valid_o && trans_ready_i;
  assign fc_if.ready   = accepted;

  // Bit 0 may be set by a pointer target, sequential fetch is word aligned
  assign addr_incr = {addr_q[`FETCH_AW-1:1], 1'b0} + `FETCH_AW'(4);

  ////////////////////////////////////////
  // Address select FSM
  ////////////////////////////////////////

  always_comb
  begin
    state_d      = state_q;
    trans_addr_o = addr_q;
    trans_ptr_o  = ptr_q;
    trans_priv_o = priv_q;

    case (state_q)
      IDLE:
      begin
        if (fc_if.branch)
        begin
          trans_addr_o = fc_if.branch_addr;
          trans_ptr_o  = fc_if.ptr;
          trans_priv_o = fc_if.priv;
          // Target not taken by the bus yet, hold it
          if (!accepted)
          begin
            state_d = BRANCH_WAIT;
          end
        end
        else
        begin
          // Sequential fetch never carries the pointer flag
          trans_addr_o = addr_incr;
          trans_ptr_o  = 1'b0;
          trans_priv_o = fc_if.priv;
        end
      end

      BRANCH_WAIT:
      begin
        // A newer branch replaces the pending target
        if (fc_if.branch)
        begin
          trans_addr_o = fc_if.branch_addr;
          trans_ptr_o  = fc_if.ptr;
          trans_priv_o = fc_if.priv;
        end
        // Back to sequential fetch once the target is granted
        if (accepted)
        begin
          state_d = IDLE;
        end
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      addr_q  <= '0;
      ptr_q   <= 1'b0;
      priv_q  <= PRIV_LVL_M;
    end
    else
    begin
      state_q <= state_d;
      // Capture on a new target or on every granted fetch
      if (fc_if.branch || accepted)
      begin
        addr_q <= trans_addr_o;
        ptr_q  <= trans_ptr_o;
        priv_q <= trans_priv_o;
      end
    end
  end

endmodule

//--- src/fetch_resp_fifo.sv
// Circular queue of returned instruction words with flush
`include "fetch_defs.svh"

module fetch_resp_fifo
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Bus response strobe and data
  input  logic                 rvalid_i,
  input  logic [`FETCH_DW-1:0] rdata_i,

  // Queue status and control
  fetch_resp_if.fifo           rs_if
);

  localparam int PTR_W = $clog2(`FETCH_DEPTH);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`FETCH_DEPTH - 1);

  logic [`FETCH_DW-1:0]    mem [`FETCH_DEPTH];
  logic [PTR_W-1:0]        wptr_q;
  logic [PTR_W-1:0]        rptr_q;
  logic [`FETCH_CNT_W-1:0] count_q;

  logic                    do_write;
  logic                    do_pop;

  // Flush wins over a write in the same cycle
  assign do_write = rvalid_i && rs_if.keep && !rs_if.flush;
  assign do_pop   = rs_if.pop && (count_q != '0) && !rs_if.flush;

  assign rs_if.not_empty = (count_q != '0);
  assign rs_if.head      = mem[rptr_q];

  // Pointers and fill count
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end
    else if (rs_if.flush)
    begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end
    else
    begin
      if (do_write)
        wptr_q <= (wptr_q == LAST) ? '0 : wptr_q + PTR_W'(1);
      if (do_pop)
        rptr_q <= (rptr_q == LAST) ? '0 : rptr_q + PTR_W'(1);
      if (do_write && !do_pop)
        count_q <= count_q + `FETCH_CNT_W'(1);
      else if (!do_write && do_pop)
        count_q <= count_q - `FETCH_CNT_W'(1);
    end
  end

  // Word storage
  always_ff @(posedge clk)
  begin
    if (do_write)
    begin
      mem[wptr_q] <= rdata_i;
    end
  end

endmodule

//--- prefetch/fetch_issue_ctrl.sv
// Outstanding and stale accounting, PC tracking and decode output stage
`include "fetch_defs.svh"

module fetch_issue_ctrl import fetch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Branch redirect from the core
  input  logic                 branch_i,
  input  logic [`FETCH_AW-1:0] branch_addr_i,
  input  logic                 branch_ptr_i,
  input  privlvl_t             priv_i,

  // Prefetcher and response FIFO
  fetch_ctrl_if.ctrl           fc_if,
  fetch_resp_if.ctrl           rs_if,
  input  logic                 rvalid_i,

  // Decode handshake
  output logic                 instr_valid_o,
  input  logic                 instr_ready_i,
  output logic [`FETCH_DW-1:0] instr_rdata_o,
  output logic [`FETCH_AW-1:0] instr_pc_o,
  output logic                 instr_ptr_o
);

  // Accepted requests still waiting for a response
  logic [`FETCH_CNT_W-1:0] outst_q;
  logic [`FETCH_CNT_W-1:0] outst_d;
  // In-flight requests whose responses get dropped
  logic [`FETCH_CNT_W-1:0] discard_q;
  logic [`FETCH_CNT_W-1:0] discard_d;
  // Words sitting in the FIFO
  logic [`FETCH_CNT_W-1:0] queued_q;
  logic [`FETCH_CNT_W-1:0] queued_d;
  // Sum needs one extra bit
  logic [`FETCH_CNT_W:0]   in_use;

  // Set by the first branch after reset
  logic                    started_q;

  logic [`FETCH_AW-1:0]    pc_q;
  logic                    ptr_q;

  logic                    accept;
  logic                    live;
  logic                    pop;

  ////////////////////////////////////////
  // Fetch throttle
  ////////////////////////////////////////

  assign in_use = {1'b0, outst_q} + {1'b0, queued_q};

  // Only fetch when every outstanding word is sure to fit in the FIFO
  // Nothing goes out before a start address is known
  assign fc_if.valid       = (started_q || branch_i) &&
                             (in_use < (`FETCH_CNT_W+1)'(`FETCH_DEPTH));
  assign fc_if.branch      = branch_i;
  assign fc_if.branch_addr = branch_addr_i;
  assign fc_if.ptr         = branch_ptr_i;
  assign fc_if.priv        = priv_i;

  assign accept = fc_if.valid && fc_if.ready;

  // Responses are live once the stale ones have drained
  assign rs_if.keep  = (discard_q == '0);
  assign live        = rvalid_i && rs_if.keep;
  assign rs_if.flush = branch_i;

  // Decode output straight from the FIFO head
  assign instr_valid_o = rs_if.not_empty;
  assign instr_rdata_o = rs_if.head;
  assign instr_pc_o    = pc_q;
  assign instr_ptr_o   = ptr_q;
  assign pop           = instr_valid_o && instr_ready_i;
  assign rs_if.pop     = pop;

  ////////////////////////////////////////
  // Counter next state
  ////////////////////////////////////////

  always_comb
  begin
    outst_d   = outst_q;
    discard_d = discard_q;
    queued_d  = queued_q;

    // One request in, one response out
    if (accept && !rvalid_i)
      outst_d = outst_q + `FETCH_CNT_W'(1);
    else if (!accept && rvalid_i)
      outst_d = outst_q - `FETCH_CNT_W'(1);

    if (branch_i)
    begin
      // Everything in flight before the branch is now stale
      // A request accepted this cycle already carries the target
      discard_d = outst_q - `FETCH_CNT_W'(rvalid_i);
      queued_d  = '0;
    end
    else
    begin
      if (rvalid_i && (discard_q != '0))
        discard_d = discard_q - `FETCH_CNT_W'(1);
      if (live && !pop)
        queued_d = queued_q + `FETCH_CNT_W'(1);
      else if (!live && pop)
        queued_d = queued_q - `FETCH_CNT_W'(1);
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      outst_q   <= '0;
      discard_q <= '0;
      queued_q  <= '0;
      started_q <= 1'b0;
      pc_q      <= '0;
      ptr_q     <= 1'b0;
    end
    else
    begin
      outst_q   <= outst_d;
      discard_q <= discard_d;
      queued_q  <= queued_d;
      // Branch wins over a same-cycle pop
      if (branch_i)
      begin
        started_q <= 1'b1;
        pc_q      <= branch_addr_i;
        ptr_q     <= branch_ptr_i;
      end
      else if (pop)
      begin
        pc_q  <= pc_q + `FETCH_AW'(4);
        // Pointer flag only on the branch target word
        ptr_q <= 1'b0;
      end
    end
  end

endmodule

//--- src/fetch_unit_top.sv
// Prefetch subsystem top with bus and decode ports
`include "fetch_defs.svh"

module fetch_unit_top import fetch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Branch redirect from the core
  input  logic                 branch_i,
  input  logic [`FETCH_AW-1:0] branch_addr_i,
  input  logic                 branch_ptr_i,
  input  privlvl_t             priv_i,

  // Instruction bus request
  output logic                 instr_req_o,
  input  logic                 instr_gnt_i,
  output logic [`FETCH_AW-1:0] instr_addr_o,
  output logic                 instr_bus_ptr_o,
  output privlvl_t             instr_priv_o,

  // Instruction bus response
  input  logic                 instr_rvalid_i,
  input  logic [`FETCH_DW-1:0] instr_rdata_i,

  // Decode handshake
  output logic                 instr_valid_o,
  input  logic                 instr_ready_i,
  output logic [`FETCH_DW-1:0] instr_rdata_o,
  output logic [`FETCH_AW-1:0] instr_pc_o,
  output logic                 instr_ptr_o
);

  fetch_ctrl_if fc_if ();
  fetch_resp_if rs_if ();

  // Address side
  fetch_prefetcher u_prefetcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .fc_if         (fc_if.pf),
    .trans_valid_o (instr_req_o),
    .trans_ready_i (instr_gnt_i),
    .trans_addr_o  (instr_addr_o),
    .trans_ptr_o   (instr_bus_ptr_o),
    .trans_priv_o  (instr_priv_o)
  );

  // Data side
  fetch_resp_fifo u_resp_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .rvalid_i (instr_rvalid_i),
    .rdata_i  (instr_rdata_i),
    .rs_if    (rs_if.fifo)
  );

  // Throttle, discard and decode stage
  fetch_issue_ctrl u_issue_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .branch_ptr_i  (branch_ptr_i),
    .priv_i        (priv_i),
    .fc_if         (fc_if.ctrl),
    .rs_if         (rs_if.ctrl),
    .rvalid_i      (instr_rvalid_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_rdata_o (instr_rdata_o),
    .instr_pc_o    (instr_pc_o),
    .instr_ptr_o   (instr_ptr_o)
  );

endmodule

//--- testbench/fetch_unit_props.sv
// Bound assertions on bus responses, decode hold and reset request level
`include "fetch_defs.svh"

module fetch_unit_props
(
  input logic                 clk,
  input logic                 rst_n,
  input logic                 branch_i,
  input logic                 instr_req_o,
  input logic                 instr_gnt_i,
  input logic                 instr_rvalid_i,
  input logic                 instr_valid_o,
  input logic                 instr_ready_i,
  input logic [`FETCH_DW-1:0] instr_rdata_o,
  input logic [`FETCH_AW-1:0] instr_pc_o
);

  // Accepted requests not yet answered
  logic [3:0] pend_q;
  int         fail_count;

  initial fail_count = 0;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pend_q <= '0;
    else
      pend_q <= pend_q + 4'(instr_req_o && instr_gnt_i) - 4'(instr_rvalid_i);
  end

  // Every response answers an earlier grant
  a_rvalid_after_grant: assert property (
    @(posedge clk) disable iff (!rst_n) instr_rvalid_i |-> (pend_q != '0))
  else
  begin
    $error("response with no accepted request");
    fail_count++;
  end

  // Decode word holds until taken unless a branch withdraws it
  a_valid_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    instr_valid_o && !instr_ready_i && !branch_i |=>
      instr_valid_o && $stable(instr_rdata_o) && $stable(instr_pc_o))
  else
  begin
    $error("decode word changed before it was taken");
    fail_count++;
  end

  a_req_low_in_reset: assert property (
    @(posedge clk) !rst_n |-> !instr_req_o)
  else
  begin
    $error("bus request during reset");
    fail_count++;
  end

endmodule

bind fetch_unit_top fetch_unit_props props (
  .clk            (clk),
  .rst_n          (rst_n),
  .branch_i       (branch_i),
  .instr_req_o    (instr_req_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .instr_valid_o  (instr_valid_o),
  .instr_ready_i  (instr_ready_i),
  .instr_rdata_o  (instr_rdata_o),
  .instr_pc_o     (instr_pc_o)
);

//--- testbench/fetch_unit_tb.sv
// Prefetch subsystem testbench with bus memory model, stream monitor and directed tests
`include "fetch_defs.svh"

module fetch_unit_tb import fetch_pkg::*; ();

  // Bus data is the word address XOR this pattern
  localparam logic [`FETCH_DW-1:0] DATA_PAT   = 32'hA5C3_0F96;
  localparam int                   WAIT_LIMIT = 300;

  logic                 clk;
  logic                 rst_n;
  logic                 branch_i;
  logic [`FETCH_AW-1:0] branch_addr_i;
  logic                 branch_ptr_i;
  privlvl_t             priv_i;
  logic                 instr_req_o;
  logic                 instr_gnt_i;
  logic [`FETCH_AW-1:0] instr_addr_o;
  logic                 instr_bus_ptr_o;
  privlvl_t             instr_priv_o;
  logic                 instr_rvalid_i;
  logic [`FETCH_DW-1:0] instr_rdata_i;
  logic                 instr_valid_o;
  logic                 instr_ready_i;
  logic [`FETCH_DW-1:0] instr_rdata_o;
  logic [`FETCH_AW-1:0] instr_pc_o;
  logic                 instr_ptr_o;

  // Memory model state
  logic [`FETCH_AW-1:0] bus_addr_q [$];
  int                   bus_due_q  [$];
  int                   cyc;
  int                   resp_delay;
  logic                 gnt_on;

  // Words delivered to decode since the last branch
  logic [`FETCH_AW-1:0] rx_pc   [$];
  logic [`FETCH_DW-1:0] rx_data [$];
  logic                 rx_ptr  [$];
  int                   stream_acc;
  int                   stream_cons;
  logic                 exp_bus_ptr;

  string                cur_test;

  fetch_unit_top UUT (.*);

  ////////////////////////////////////////
  // Clock and memory model
  ////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Random grant per cycle and in-order responses after 1 to 4 cycles
  initial
  begin
    void'($urandom(88140));
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    cyc            = 0;
    resp_delay     = 1;
    forever
    begin
      @(posedge clk);
      #1;
      cyc++;
      resp_delay  = 1 + int'($urandom % 4);
      instr_gnt_i = gnt_on && (($urandom % 4) != 0);
      if ((bus_addr_q.size() != 0) && (bus_due_q[0] <= cyc))
      begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = bus_addr_q[0] ^ DATA_PAT;
        void'(bus_addr_q.pop_front());
        void'(bus_due_q.pop_front());
      end
      else
      begin
        instr_rvalid_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Failure handling and checks
  ////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run stopped after a failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act)
      stop_run($sformatf("error %s %s: expected %h actual %h", cur_test, what, exp, act));
  endtask

  // Bus and decode monitor on the falling edge
  always @(negedge clk)
  begin
    if (UUT.props.fail_count != 0)
      stop_run("a bound assertion failed during the run");
    if (rst_n)
    begin
      // A word popped in the branch cycle still belongs to the old stream
      if (instr_valid_o && instr_ready_i && !branch_i)
      begin
        rx_pc.push_back(instr_pc_o);
        rx_data.push_back(instr_rdata_o);
        rx_ptr.push_back(instr_ptr_o);
        stream_cons++;
      end
      if (branch_i)
      begin
        stream_acc  = 0;
        stream_cons = 0;
        exp_bus_ptr = branch_ptr_i;
      end
      if (instr_req_o && instr_gnt_i)
      begin
        // Pointer flag only on the first transaction after a pointer branch
        check_value("bus ptr", exp_bus_ptr, instr_bus_ptr_o);
        check_value("bus priv", priv_i, instr_priv_o);
        exp_bus_ptr = 1'b0;
        bus_addr_q.push_back(instr_addr_o);
        bus_due_q.push_back(cyc + resp_delay);
        stream_acc++;
      end
      if ((stream_acc - stream_cons) > `FETCH_DEPTH)
        check_value("outstanding", `FETCH_DEPTH, stream_acc - stream_cons);
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // One-cycle redirect that drops the record of the old stream
  task automatic drive_branch(input logic [`FETCH_AW-1:0] addr, input logic ptr);
    step();
    branch_i      = 1'b1;
    branch_addr_i = addr;
    branch_ptr_i  = ptr;
    rx_pc.delete();
    rx_data.delete();
    rx_ptr.delete();
    step();
    branch_i     = 1'b0;
    branch_ptr_i = 1'b0;
  endtask

  task automatic wait_words(input int n);
    int waited;
    waited = 0;
    while (rx_pc.size() < n)
    begin
      step();
      waited++;
      if (waited > WAIT_LIMIT)
        stop_run($sformatf("%s: only %0d of %0d instructions arrived in time",
                           cur_test, rx_pc.size(), n));
    end
  endtask

  // Sequential words from start with the flag on the first one only
  task automatic compare_stream(input logic [`FETCH_AW-1:0] start, input int n,
                                input logic first_ptr);
    logic [`FETCH_AW-1:0] pc;
    int                   i;
    for (i = 0; i < n; i++)
    begin
      pc = start + `FETCH_AW'(4 * i);
      check_value("pc", pc, rx_pc[i]);
      check_value("data", pc ^ DATA_PAT, rx_data[i]);
      check_value("decode ptr", (i == 0) ? first_ptr : 1'b0, rx_ptr[i]);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic sequential_fetch();
    cur_test = "sequential";
    instr_ready_i = 1'b1;
    // Nothing is fetched or delivered before the first start address
    repeat (3)
    begin
      @(negedge clk);
      check_value("req before branch", 1'b0, instr_req_o);
      check_value("valid before branch", 1'b0, instr_valid_o);
    end
    drive_branch(32'h0000_1000, 1'b0);
    wait_words(12);
    compare_stream(32'h0000_1000, 12, 1'b0);
  endtask

  task automatic outstanding_limit();
    int waited;
    cur_test = "outstanding";
    waited = 0;
    step();
    instr_ready_i = 1'b0;
    drive_branch(32'h0000_2000, 1'b0);
    while ((stream_acc - stream_cons) < `FETCH_DEPTH)
    begin
      step();
      waited++;
      if (waited > WAIT_LIMIT)
        stop_run("outstanding: the queue never filled while decode was stalled");
    end
    // Queue is full and the bus sees no request
    repeat (8)
    begin
      @(negedge clk);
      check_value("req while full", 1'b0, instr_req_o);
    end
    step();
    instr_ready_i = 1'b1;
    wait_words(10);
    compare_stream(32'h0000_2000, 10, 1'b0);
  endtask

  task automatic branch_redirect();
    int waited;
    cur_test = "redirect";
    waited = 0;
    drive_branch(32'h0000_3000, 1'b0);
    wait_words(3);
    // Redirect with old requests still in flight
    while (bus_addr_q.size() < 2)
    begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > WAIT_LIMIT)
        stop_run("redirect: never saw two requests in flight");
    end
    drive_branch(32'h0000_4000, 1'b0);
    wait_words(8);
    compare_stream(32'h0000_4000, 8, 1'b0);
  endtask

  task automatic grant_hold();
    int waited;
    cur_test = "grant hold";
    waited = 0;
    @(negedge clk);
    gnt_on = 1'b0;
    // Let every old response drain first
    while (bus_addr_q.size() != 0)
    begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > WAIT_LIMIT)
        stop_run("grant hold: bus responses did not drain");
    end
    drive_branch(32'h0000_6000, 1'b0);
    repeat (3)
    begin
      @(negedge clk);
      check_value("req first target", 1'b1, instr_req_o);
      check_value("addr first target", 32'h0000_6000, instr_addr_o);
    end
    // Newer target replaces the pending one
    drive_branch(32'h0000_7000, 1'b0);
    repeat (3)
    begin
      @(negedge clk);
      check_value("req second target", 1'b1, instr_req_o);
      check_value("addr second target", 32'h0000_7000, instr_addr_o);
    end
    gnt_on = 1'b1;
    wait_words(6);
    compare_stream(32'h0000_7000, 6, 1'b0);
  endtask

  task automatic pointer_priv();
    cur_test = "pointer";
    step();
    priv_i = PRIV_LVL_U;
    drive_branch(32'h0000_8000, 1'b1);
    wait_words(6);
    compare_stream(32'h0000_8000, 6, 1'b1);
    // Privilege change in mid-stream shows up on the bus
    step();
    priv_i = PRIV_LVL_M;
    wait_words(12);
    compare_stream(32'h0000_8000, 12, 1'b1);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    rst_n         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    branch_ptr_i  = 1'b0;
    priv_i        = PRIV_LVL_M;
    instr_ready_i = 1'b0;
    gnt_on        = 1'b1;
    stream_acc    = 0;
    stream_cons   = 0;
    exp_bus_ptr   = 1'b0;
    cur_test      = "reset";
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    sequential_fetch();
    outstanding_limit();
    branch_redirect();
    grant_hold();
    pointer_priv();

    repeat (4) step();
    if (UUT.props.fail_count != 0)
      stop_run("bound assertions reported failures during the run");
    else
    begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- list.f
+incdir+common
common/fetch_pkg.sv
common/fetch_ctrl_if.sv
common/fetch_resp_if.sv
prefetch/fetch_prefetcher.sv
src/fetch_resp_fifo.sv
prefetch/fetch_issue_ctrl.sv
src/fetch_unit_top.sv
testbench/fetch_unit_props.sv
testbench/fetch_unit_tb.sv
